/* tb.f */
+incdir+verilog
verilog/dbg_pkg.sv
verilog/lane_dbg_intf.sv
verilog/jtag_tap.sv
verilog/prbs_lane.sv
verilog/lane_status_sel.sv
verilog/dbg_top.sv
verif/tb_clock.sv
verif/dbg_assert.sv
verif/dbg_tb.sv

/* Bender.yml */
package:
  name: dbg_jtag

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/dbg_pkg.sv
      - verilog/lane_dbg_intf.sv
      - verilog/jtag_tap.sv
      - verilog/prbs_lane.sv
      - verilog/lane_status_sel.sv
      - verilog/dbg_top.sv
  - target: simulation
    files:
      - verif/tb_clock.sv
      - verif/dbg_assert.sv
      - verif/dbg_tb.sv

/* verif/dbg_tb.sv */
`include "dbg_settings.svh"

module dbg_tb;
	timeunit 1ns;
	timeprecision 100ps;

	// IR and DR scans over all tests
	localparam int NUM_SCANS = 46;
	localparam int N_CLEAN = 100;
	localparam int N_ERR = 200;
	localparam int N_HOLD = 60;

	logic clk;
	logic reset;
	logic tck;
	logic tms;
	logic tdi;
	logic trst_n;
	logic tdo;
	logic [`DBG_NUM_LANES-1:0] lane_bit;
	logic [`DBG_NUM_LANES-1:0] lane_valid;
	logic [6:0] gen_state = 7'h5a;
	// Reference predictor for lane 2, newest bit in hist2[0]
	logic [6:0] hist2;
	int seen2 = 0;
	int exp_err2 = 0;
	int checks = 0;
	int errors = 0;
	int tests = 0;

	tb_clock clock_i (.clk_o(clk), .reset_o(reset));

	dbg_top dbg_top_i (
		.clk(clk),
		.reset_i(reset),
		.tck_i(tck),
		.tms_i(tms),
		.tdi_i(tdi),
		.trst_n_i(trst_n),
		.tdo_o(tdo),
		.lane_bit_i(lane_bit),
		.lane_bit_valid_i(lane_valid)
	);

	bind jtag_tap dbg_assert tap_chk_i (
		.clk(clk), .reset_i(reset_i), .stb_i({rd_stb_o, cfg_stb_q}),
		.clear_i(1'b0), .bit_cnt_i('0), .err_cnt_i('0)
	);

	bind prbs_lane dbg_assert lane_chk_i (
		.clk(clk), .reset_i(reset_i), .stb_i({{`DBG_NUM_LANES{1'b0}}, dbg.cfg_stb}),
		.clear_i(dbg.cfg_stb & dbg.cfg_clear),
		.bit_cnt_i(dbg.bit_count), .err_cnt_i(dbg.err_count)
	);

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// One tck period, tdo sampled just before the rising edge
	task automatic tck_cycle(input logic tms_v, input logic tdi_v, output logic tdo_v);
		tck <= 1'b0;
		tms <= tms_v;
		tdi <= tdi_v;
		repeat (4) @(posedge clk);
		tdo_v = tdo;
		tck <= 1'b1;
		repeat (4) @(posedge clk);
	endtask

	task automatic ir_scan(input logic [`DBG_IR_W-1:0] code);
		logic unused;
		tck_cycle(1'b1, 1'b0, unused);
		tck_cycle(1'b1, 1'b0, unused);
		tck_cycle(1'b0, 1'b0, unused);
		tck_cycle(1'b0, 1'b0, unused);
		for (int i = 0; i < `DBG_IR_W; i++) begin
			tck_cycle(i == `DBG_IR_W - 1, code[i], unused);
		end
		tck_cycle(1'b1, 1'b0, unused);
		tck_cycle(1'b0, 1'b0, unused);
	endtask

	task automatic dr_scan(input logic [31:0] din, output logic [31:0] dout);
		logic unused;
		tck_cycle(1'b1, 1'b0, unused);
		tck_cycle(1'b0, 1'b0, unused);
		tck_cycle(1'b0, 1'b0, unused);
		for (int i = 0; i < 32; i++) begin
			tck_cycle(i == 31, din[i], dout[i]);
		end
		// Update-DR, then back to Run-Test/Idle
		tck_cycle(1'b1, 1'b0, unused);
		tck_cycle(1'b0, 1'b0, unused);
	endtask

	task automatic cfg_write(input logic [3:0] mask, input logic en, input logic clr);
		logic [31:0] unused;
		ir_scan(`DBG_INS_CFG);
		dr_scan({26'b0, clr, en, mask}, unused);
		if (mask[2] && clr) begin
			seen2 = 0;
			exp_err2 = 0;
		end
	endtask

	// First scan selects, second returns the snapshot
	task automatic read_counter(input int lane, input logic err_sel, output logic [31:0] value);
		logic [31:0] unused;
		dr_scan({29'b0, err_sel, 2'(lane)}, unused);
		dr_scan({29'b0, err_sel, 2'(lane)}, value);
	endtask

	task automatic send_bits(input int n, input bit inject);
		logic b;
		logic b2;
		int next_flip;
		next_flip = 8 + $urandom_range(15);
		for (int i = 0; i < n; i++) begin
			// x^7 + x^6 + 1
			b = gen_state[6] ^ gen_state[5];
			gen_state = {gen_state[5:0], b};
			b2 = b;
			if (inject && i == next_flip && i < n - 8) begin
				b2 = ~b;
				next_flip = i + 9 + $urandom_range(15);
			end
			if (seen2 >= 7 && b2 != (hist2[6] ^ hist2[5])) begin
				exp_err2++;
			end
			hist2 = {hist2[5:0], b2};
			seen2++;
			lane_bit <= {b, b2, b, b};
			lane_valid <= '1;
			@(posedge clk);
		end
		lane_valid <= '0;
		@(posedge clk);
	endtask

	task automatic idcode_after_reset();
		logic [31:0] dout;
		dr_scan('0, dout);
		check_eq("tdo_o idcode", dout, `DBG_IDCODE);
	endtask

	task automatic bypass_delay();
		logic [31:0] pat;
		logic [31:0] dout;
		pat = $urandom();
		ir_scan(`DBG_INS_BYPASS);
		dr_scan(pat, dout);
		check_eq("tdo_o bypass", dout, {pat[30:0], 1'b0});
	endtask

	task automatic clean_stream_counts();
		logic [31:0] v;
		cfg_write(4'hf, 1'b1, 1'b1);
		send_bits(N_CLEAN, 1'b0);
		ir_scan(`DBG_INS_STAT);
		for (int l = 0; l < `DBG_NUM_LANES; l++) begin
			read_counter(l, 1'b0, v);
			check_eq($sformatf("lane%0d bit_count", l), v, N_CLEAN);
			read_counter(l, 1'b1, v);
			check_eq($sformatf("lane%0d err_count", l), v, 0);
		end
	endtask

	task automatic injected_errors();
		logic [31:0] v;
		cfg_write(4'hf, 1'b1, 1'b1);
		send_bits(N_ERR, 1'b1);
		ir_scan(`DBG_INS_STAT);
		for (int l = 0; l < `DBG_NUM_LANES; l++) begin
			read_counter(l, 1'b1, v);
			check_eq($sformatf("lane%0d err_count", l), v, l == 2 ? exp_err2 : 0);
		end
	endtask

	task automatic masked_clear_and_hold();
		logic [31:0] v;
		int exp [`DBG_NUM_LANES];
		exp = '{N_HOLD, N_HOLD, N_ERR + N_HOLD, N_ERR};
		cfg_write(4'b0011, 1'b1, 1'b1);
		// Lane 3 stops counting
		cfg_write(4'b1000, 1'b0, 1'b0);
		send_bits(N_HOLD, 1'b0);
		ir_scan(`DBG_INS_STAT);
		for (int l = 0; l < `DBG_NUM_LANES; l++) begin
			read_counter(l, 1'b0, v);
			check_eq($sformatf("lane%0d bit_count", l), v, exp[l]);
		end
	endtask

	task automatic end_test(input string name, input int err_before);
		tests++;
		if (errors == err_before) begin
			$display("%0t %s: ok", $time, name);
		end else begin
			$display("%0t %s: %0d errors", $time, name, errors - err_before);
		end
	endtask

	initial begin
		int err_before;
		int assert_fails;
		logic unused;
		void'($urandom(32'ha80a));
		tck = 1'b0;
		tms = 1'b1;
		tdi = 1'b0;
		trst_n = 1'b1;
		lane_bit = '0;
		lane_valid = '0;
		wait (!reset);
		@(posedge clk);
		// Test-Logic-Reset to Run-Test/Idle
		tck_cycle(1'b0, 1'b0, unused);
		err_before = errors;
		idcode_after_reset();
		end_test("idcode after reset", err_before);
		err_before = errors;
		bypass_delay();
		end_test("bypass delay", err_before);
		err_before = errors;
		clean_stream_counts();
		end_test("clean stream counts", err_before);
		err_before = errors;
		injected_errors();
		end_test("injected errors", err_before);
		err_before = errors;
		masked_clear_and_hold();
		end_test("masked clear and hold", err_before);
		assert_fails = dbg_top_i.tap_i.tap_chk_i.fail_cnt;
		assert_fails += dbg_top_i.g_lane[0].lane_i.lane_chk_i.fail_cnt;
		assert_fails += dbg_top_i.g_lane[1].lane_i.lane_chk_i.fail_cnt;
		assert_fails += dbg_top_i.g_lane[2].lane_i.lane_chk_i.fail_cnt;
		assert_fails += dbg_top_i.g_lane[3].lane_i.lane_chk_i.fail_cnt;
		errors += assert_fails;
		$display("tests %0d, checks %0d, assertion failures %0d, errors %0d",
			tests, checks, assert_fails, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	// Each scan stays well under 80 tck half-periods of 400 ns
	initial begin
		#(NUM_SCANS * 80 * 400 * 2);
		$display("Timeout: tests did not complete in time at %0t", $time);
		$display("TEST FAIL");
		$finish;
	end

endmodule

/* verif/dbg_assert.sv */
`include "dbg_settings.svh"

module dbg_assert (
	input wire logic clk,
	input wire logic reset_i,
	input wire logic [`DBG_NUM_LANES:0] stb_i,
	input wire logic clear_i,
	input wire dbg_pkg::cnt_t bit_cnt_i,
	input wire dbg_pkg::cnt_t err_cnt_i
);
	timeunit 1ns;
	timeprecision 100ps;

	int fail_cnt = 0;

	// Update strobes last a single clk
	stb_single_a: assert property (@(posedge clk) disable iff (reset_i)
		(stb_i & $past(stb_i)) == '0)
	else begin
		$error("strobe high on two consecutive clk cycles");
		fail_cnt++;
	end

	stb_reset_a: assert property (@(posedge clk) $past(reset_i) |-> stb_i == '0)
	else begin
		$error("strobe high during reset");
		fail_cnt++;
	end

	// Only a clear strobe brings a counter down
	cnt_mono_a: assert property (@(posedge clk) disable iff (reset_i)
		!$past(clear_i) |-> bit_cnt_i >= $past(bit_cnt_i) && err_cnt_i >= $past(err_cnt_i))
	else begin
		$error("lane counter decreased without a clear");
		fail_cnt++;
	end

endmodule

/* verif/tb_clock.sv */
module tb_clock (
	output logic clk_o,
	output logic reset_o
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk_o = 1'b0;
		forever #50 clk_o = ~clk_o;
	end

	// Two clk cycles of reset
	initial begin
		reset_o = 1'b1;
		repeat (2) @(posedge clk_o);
		reset_o <= 1'b0;
	end

endmodule

/* verilog/dbg_top.sv */
`default_nettype none
`include "dbg_settings.svh"

module dbg_top (
	input  wire logic clk,
	input  wire logic reset_i,
	input  wire logic tck_i,
	input  wire logic tms_i,
	input  wire logic tdi_i,
	input  wire logic trst_n_i,
	output logic tdo_o,
	input  wire logic [`DBG_NUM_LANES-1:0] lane_bit_i,
	input  wire logic [`DBG_NUM_LANES-1:0] lane_bit_valid_i
);
	import dbg_pkg::*;

	logic rd_stb;
	lane_idx_t rd_lane;
	logic rd_err_sel;
	logic [`DBG_DR_W-1:0] status_word;

	lane_dbg_intf lane_if [`DBG_NUM_LANES] ();

	jtag_tap tap_i (
		.clk(clk),
		.reset_i(reset_i),
		.tck_i(tck_i),
		.tms_i(tms_i),
		.tdi_i(tdi_i),
		.trst_n_i(trst_n_i),
		.tdo_o(tdo_o),
		.lane_o(lane_if),
		.rd_stb_o(rd_stb),
		.rd_lane_o(rd_lane),
		.rd_err_sel_o(rd_err_sel),
		.status_word_i(status_word)
	);

	for (genvar i = 0; i < `DBG_NUM_LANES; i++) begin : g_lane
		prbs_lane lane_i (
			.clk(clk),
			.reset_i(reset_i),
			.bit_i(lane_bit_i[i]),
			.bit_valid_i(lane_bit_valid_i[i]),
			.dbg(lane_if[i])
		);
	end

	lane_status_sel sel_i (
		.clk(clk),
		.reset_i(reset_i),
		.lanes(lane_if),
		.rd_stb_i(rd_stb),
		.rd_lane_i(rd_lane),
		.rd_err_sel_i(rd_err_sel),
		.status_word_o(status_word)
	);

endmodule

`default_nettype wire

/* verilog/lane_status_sel.sv */
`default_nettype none
`include "dbg_settings.svh"

module lane_status_sel (
	input  wire logic clk,
	input  wire logic reset_i,
	lane_dbg_intf.sel lanes [`DBG_NUM_LANES],
	input  wire logic rd_stb_i,
	input  wire dbg_pkg::lane_idx_t rd_lane_i,
	input  wire logic rd_err_sel_i,
	output logic [`DBG_DR_W-1:0] status_word_o
);
	import dbg_pkg::*;

	cnt_t bit_counts [`DBG_NUM_LANES];
	cnt_t err_counts [`DBG_NUM_LANES];
	cnt_t sel_cnt;

	for (genvar i = 0; i < `DBG_NUM_LANES; i++) begin : g_lane
		assign bit_counts[i] = lanes[i].bit_count;
		assign err_counts[i] = lanes[i].err_count;
	end

	assign sel_cnt = rd_err_sel_i ? err_counts[rd_lane_i] : bit_counts[rd_lane_i];

	// Snapshot held for the next Capture-DR
	always_ff @(posedge clk) begin
		if (reset_i) begin
			status_word_o <= '0;
		end else if (rd_stb_i) begin
			status_word_o <= {{(`DBG_DR_W-`DBG_CNT_W){1'b0}}, sel_cnt};
		end
	end

endmodule

`default_nettype wire

/* verilog/prbs_lane.sv */
`default_nettype none
`include "dbg_settings.svh"

module prbs_lane (
	input  wire logic clk,
	input  wire logic reset_i,
	input  wire logic bit_i,
	input  wire logic bit_valid_i,
	lane_dbg_intf.lane dbg
);
	import dbg_pkg::*;

	localparam cnt_t CNT_MAX = '1;

	logic bit_q;
	logic valid_q;
	// hist[0] is the newest received bit
	logic [6:0] hist;
	logic enable_q;
	logic [2:0] warm_cnt;
	logic warm;
	logic mismatch;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= bit_valid_i;
		end
	end

	always_ff @(posedge clk) begin
		if (bit_valid_i) begin
			bit_q <= bit_i;
		end
		if (valid_q) begin
			hist <= {hist[5:0], bit_q};
		end
	end

	// x^7 + x^6 + 1, predicted from the received history
	assign mismatch = bit_q != (hist[6] ^ hist[5]);
	assign warm = warm_cnt == 3'd7;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			enable_q <= 1'b0;
			warm_cnt <= '0;
			dbg.bit_count <= '0;
			dbg.err_count <= '0;
		end else begin
			if (dbg.cfg_stb) begin
				enable_q <= dbg.cfg_enable;
			end
			// Restart warm-up on clear or on a fresh enable
			if (dbg.cfg_stb && (dbg.cfg_clear || !enable_q)) begin
				warm_cnt <= '0;
			end else if (enable_q && valid_q && !warm) begin
				warm_cnt <= warm_cnt + 3'd1;
			end
			if (dbg.cfg_stb && dbg.cfg_clear) begin
				dbg.bit_count <= '0;
				dbg.err_count <= '0;
			end else if (enable_q && valid_q) begin
				if (dbg.bit_count != CNT_MAX) begin
					dbg.bit_count <= dbg.bit_count + 1'b1;
				end
				if (warm && mismatch && dbg.err_count != CNT_MAX) begin
					dbg.err_count <= dbg.err_count + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/jtag_tap.sv */
`default_nettype none
`include "dbg_settings.svh"

module jtag_tap (
	input  wire logic clk,
	input  wire logic reset_i,
	input  wire logic tck_i,
	input  wire logic tms_i,
	input  wire logic tdi_i,
	input  wire logic trst_n_i,
	output logic tdo_o,
	lane_dbg_intf.tap lane_o [`DBG_NUM_LANES],
	output logic rd_stb_o,
	output dbg_pkg::lane_idx_t rd_lane_o,
	output logic rd_err_sel_o,
	input  wire logic [`DBG_DR_W-1:0] status_word_i
);
	import dbg_pkg::*;

	typedef enum logic [3:0] {
		TLR, RTI, SEL_DR, CAP_DR, SHIFT_DR, EXIT1_DR, PAUSE_DR, EXIT2_DR, UPD_DR,
		SEL_IR, CAP_IR, SHIFT_IR, EXIT1_IR, PAUSE_IR, EXIT2_IR, UPD_IR
	} tap_state_e;

	// Pin order {trst_n, tdi, tms, tck}
	logic [3:0] pin_s1;
	logic [3:0] pin_s2;
	logic tck_d;
	logic tck_rise;
	logic tck_fall;
	logic tms;
	logic tdi;
	logic trst_n;
	tap_state_e state;
	tap_state_e next_state;
	dbg_instr_e ir;
	logic [`DBG_IR_W-1:0] ir_shift;
	logic [`DBG_DR_W-1:0] dr_shift;
	dr_word_u dr_word;
	logic bypass_q;
	logic dr_is_bypass;
	logic upd_dr;
	logic [`DBG_NUM_LANES-1:0] cfg_stb_q;
	logic cfg_enable_q;
	logic cfg_clear_q;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			pin_s1 <= '0;
			pin_s2 <= '0;
			tck_d <= 1'b0;
		end else begin
			pin_s1 <= {trst_n_i, tdi_i, tms_i, tck_i};
			pin_s2 <= pin_s1;
			tck_d <= pin_s2[0];
		end
	end

	assign tck_rise = pin_s2[0] & ~tck_d;
	assign tck_fall = ~pin_s2[0] & tck_d;
	assign tms = pin_s2[1];
	assign tdi = pin_s2[2];
	assign trst_n = pin_s2[3];

	always_comb begin
		case (state)
			TLR:      next_state = tms ? TLR : RTI;
			RTI:      next_state = tms ? SEL_DR : RTI;
			SEL_DR:   next_state = tms ? SEL_IR : CAP_DR;
			CAP_DR:   next_state = tms ? EXIT1_DR : SHIFT_DR;
			SHIFT_DR: next_state = tms ? EXIT1_DR : SHIFT_DR;
			EXIT1_DR: next_state = tms ? UPD_DR : PAUSE_DR;
			PAUSE_DR: next_state = tms ? EXIT2_DR : PAUSE_DR;
			EXIT2_DR: next_state = tms ? UPD_DR : SHIFT_DR;
			UPD_DR:   next_state = tms ? SEL_DR : RTI;
			SEL_IR:   next_state = tms ? TLR : CAP_IR;
			CAP_IR:   next_state = tms ? EXIT1_IR : SHIFT_IR;
			SHIFT_IR: next_state = tms ? EXIT1_IR : SHIFT_IR;
			EXIT1_IR: next_state = tms ? UPD_IR : PAUSE_IR;
			PAUSE_IR: next_state = tms ? EXIT2_IR : PAUSE_IR;
			EXIT2_IR: next_state = tms ? UPD_IR : SHIFT_IR;
			UPD_IR:   next_state = tms ? SEL_DR : RTI;
			default:  next_state = TLR;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset_i || !trst_n) begin
			state <= TLR;
		end else if (tck_rise) begin
			state <= next_state;
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i || state == TLR) begin
			ir <= IDCODE;
		end else if (tck_rise && next_state == UPD_IR) begin
			ir <= dbg_instr_e'(ir_shift);
		end
	end

	// Unknown codes fall back to the 1-bit bypass register
	assign dr_is_bypass = !(ir inside {IDCODE, CFG, STAT});

	always_ff @(posedge clk) begin
		if (tck_rise) begin
			case (state)
				CAP_IR:   ir_shift <= {{(`DBG_IR_W-1){1'b0}}, 1'b1};
				SHIFT_IR: ir_shift <= {tdi, ir_shift[`DBG_IR_W-1:1]};
				CAP_DR: begin
					bypass_q <= 1'b0;
					case (ir)
						IDCODE:  dr_shift <= `DBG_IDCODE;
						STAT:    dr_shift <= status_word_i;
						default: dr_shift <= '0;
					endcase
				end
				SHIFT_DR: begin
					bypass_q <= tdi;
					dr_shift <= {tdi, dr_shift[`DBG_DR_W-1:1]};
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			tdo_o <= 1'b0;
		end else if (tck_fall) begin
			case (state)
				SHIFT_IR: tdo_o <= ir_shift[0];
				SHIFT_DR: tdo_o <= dr_is_bypass ? bypass_q : dr_shift[0];
				default:  tdo_o <= 1'b0;
			endcase
		end
	end

	// Same word, decoded per instruction
	assign dr_word = dr_shift;
	assign upd_dr = tck_rise && trst_n && next_state == UPD_DR;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			cfg_stb_q <= '0;
			rd_stb_o <= 1'b0;
			rd_lane_o <= '0;
			rd_err_sel_o <= 1'b0;
		end else begin
			cfg_stb_q <= '0;
			rd_stb_o <= 1'b0;
			if (upd_dr && ir == CFG) begin
				cfg_stb_q <= dr_word.cfg.mask;
			end
			if (upd_dr && ir == STAT) begin
				rd_stb_o <= 1'b1;
				rd_lane_o <= dr_word.rd.lane;
				rd_err_sel_o <= dr_word.rd.err_sel;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (upd_dr && ir == CFG) begin
			cfg_enable_q <= dr_word.cfg.enable;
			cfg_clear_q <= dr_word.cfg.clear;
		end
	end

	for (genvar i = 0; i < `DBG_NUM_LANES; i++) begin : g_lane
		assign lane_o[i].cfg_stb = cfg_stb_q[i];
		assign lane_o[i].cfg_enable = cfg_enable_q;
		assign lane_o[i].cfg_clear = cfg_clear_q;
	end

endmodule

`default_nettype wire

/* verilog/lane_dbg_intf.sv */
interface lane_dbg_intf;
	import dbg_pkg::*;

	// Configuration from the TAP, qualified by cfg_stb
	logic cfg_stb;
	logic cfg_enable;
	logic cfg_clear;

	// Live lane counters
	cnt_t bit_count;
	cnt_t err_count;

	modport tap (
		output cfg_stb, cfg_enable, cfg_clear
	);

	modport lane (
		input cfg_stb, cfg_enable, cfg_clear,
		output bit_count, err_count
	);

	modport sel (
		input bit_count, err_count
	);

endinterface

/* verilog/dbg_pkg.sv */
`include "dbg_settings.svh"

package dbg_pkg;

	typedef enum logic [`DBG_IR_W-1:0] {
		IDCODE = `DBG_INS_IDCODE,
		CFG    = `DBG_INS_CFG,
		STAT   = `DBG_INS_STAT,
		BYPASS = `DBG_INS_BYPASS
	} dbg_instr_e;

	typedef logic [`DBG_CNT_W-1:0] cnt_t;

	typedef logic [1:0] lane_idx_t;

	// Lane configuration, written under CFG
	typedef struct packed {
		logic [`DBG_DR_W-`DBG_NUM_LANES-3:0] pad;
		logic clear;
		logic enable;
		logic [`DBG_NUM_LANES-1:0] mask;
	} cfg_view_t;

	// Counter read request, written under STAT
	typedef struct packed {
		logic [`DBG_DR_W-4:0] pad;
		logic err_sel;
		lane_idx_t lane;
	} rd_view_t;

	typedef union packed {
		cfg_view_t cfg;
		rd_view_t rd;
	} dr_word_u;

endpackage

/* verilog/dbg_settings.svh */
`ifndef DBG_SETTINGS_SVH
`define DBG_SETTINGS_SVH

// Lane array and counter sizes
`define DBG_NUM_LANES 4
`define DBG_CNT_W 16

// TAP register widths
`define DBG_IR_W 4
`define DBG_DR_W 32

// Part identification returned by the IDCODE instruction
`define DBG_IDCODE 32'h1db6_0a47

// Instruction codes
`define DBG_INS_IDCODE 4'h1
`define DBG_INS_CFG 4'h2
`define DBG_INS_STAT 4'h3
`define DBG_INS_BYPASS 4'hf

`endif
